// File: design/snes_host_pkg.sv
// Shared header-decode types, fill patterns, audio sample type and cartridge constants
package snes_host_pkg;

	// ==========================================================
	// Selectors driven from the host menu
	// ==========================================================
	typedef enum logic [2:0] {
		HDR_AUTO    = 3'd0,
		HDR_NONE    = 3'd1,
		HDR_LOROM   = 3'd2,
		HDR_HIROM   = 3'd3,
		HDR_EXHIROM = 3'd4
	} rom_header_e;

	// Bit 1 of a fixed selection gives PAL
	typedef enum logic [1:0] {
		REG_AUTO    = 2'd0,
		REG_NTSC    = 2'd1,
		REG_PAL     = 2'd2,
		REG_PAL_ALT = 2'd3
	} region_e;

	typedef enum logic [1:0] {
		FILL_9966 = 2'd0,
		FILL_00FF = 2'd1,
		FILL_55   = 2'd2,
		FILL_FF   = 2'd3
	} fill_pattern_e;

	typedef logic [23:0]        mask_t;
	typedef logic signed [15:0] sample_t;

	// ==========================================================
	// Cartridge image layout
	// ==========================================================
	localparam logic [5:0] CART_INDEX          = 6'd0;
	localparam int         COPIER_HEADER_BYTES = 512;

	// ROM size word of each mapping with the RAM size in the next word
	localparam logic [23:0] LOROM_INFO   = 24'h007FD6;
	localparam logic [23:0] HIROM_INFO   = 24'h00FFD6;
	localparam logic [23:0] EXHIROM_INFO = 24'h40FFD6;

	localparam int SECTOR_BYTES_LOG2 = 9;
	localparam int LBA_BITS          = 15;

endpackage

// File: design/cart_header_detect.sv
// Cartridge header detector deriving ROM type, ROM and save-RAM masks and video region
`timescale 1ns/10ps

module cart_header_detect (
	input  logic                       clk_sys,
	input  logic                       RESET,
	input  logic                       cart_download,
	input  logic                       ioctl_wr,
	input  logic [24:0]                ioctl_addr,
	input  logic [15:0]                ioctl_dout,
	input  snes_host_pkg::rom_header_e header_mode,
	input  snes_host_pkg::region_e     region_mode,
	output logic [7:0]                 rom_type,
	output snes_host_pkg::mask_t       rom_mask,
	output snes_host_pkg::mask_t       ram_mask,
	output logic                       pal
);

	logic [3:0]  rom_size;
	logic [3:0]  ram_size;
	logic        rom_region;
	logic        mapped;
	logic [24:0] info_addr;

	// Info word location for a forced mapping including the copier header
	always_comb begin
		mapped    = 1'b1;
		info_addr = '0;
		case (header_mode)
			snes_host_pkg::HDR_LOROM:   info_addr = {1'b0, snes_host_pkg::LOROM_INFO};
			snes_host_pkg::HDR_HIROM:   info_addr = {1'b0, snes_host_pkg::HIROM_INFO};
			snes_host_pkg::HDR_EXHIROM: info_addr = {1'b0, snes_host_pkg::EXHIROM_INFO};
			default:                    mapped = 1'b0;
		endcase
		info_addr = info_addr + 25'(snes_host_pkg::COPIER_HEADER_BYTES);
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= 4'hC;
			ram_size   <= 4'h0;
			rom_type   <= 8'd0;
			rom_region <= 1'b0;
			pal        <= 1'b0;
		end else if (cart_download) begin
			if (ioctl_wr) begin
				if (ioctl_addr == 25'd0) begin
					rom_size <= 4'hC;
					ram_size <= 4'h0;
					// Auto mode trusts the size byte in front of the image
					if (header_mode == snes_host_pkg::HDR_AUTO && ioctl_dout[7:0] != 8'd0) begin
						ram_size <= ioctl_dout[7:4];
						rom_size <= ioctl_dout[3:0];
					end
					case (header_mode)
						snes_host_pkg::HDR_NONE:    rom_type <= 8'd0;
						snes_host_pkg::HDR_LOROM:   rom_type <= 8'd0;
						snes_host_pkg::HDR_HIROM:   rom_type <= 8'd1;
						snes_host_pkg::HDR_EXHIROM: rom_type <= 8'd2;
						default:                    rom_type <= ioctl_dout[15:8];
					endcase
				end
				if (ioctl_addr == 25'd2) begin
					rom_region <= ioctl_dout[8];
				end
				if (mapped && ioctl_addr == info_addr) begin
					rom_size <= ioctl_dout[11:8];
				end
				if (mapped && ioctl_addr == info_addr + 25'd2) begin
					ram_size <= ioctl_dout[3:0];
				end
			end
		end else begin
			pal <= (region_mode == snes_host_pkg::REG_AUTO) ? rom_region : region_mode[1];
		end
	end

	// Size code N means 1 KiB << N
	assign rom_mask = (snes_host_pkg::mask_t'(1024) << rom_size) - 24'd1;
	assign ram_mask = (ram_size != 4'd0) ? (snes_host_pkg::mask_t'(1024) << ram_size) - 24'd1 :
		24'd0;

endmodule

// File: design/wram_clear.sv
// Work-RAM clear sweeping every address with a power-on pattern after a cartridge download
`timescale 1ns/10ps

module wram_clear #(
	parameter int FILL_ADDR_BITS = 17
) (
	input  logic                         clk_sys,
	input  logic                         RESET,
	input  logic                         cart_download,
	input  snes_host_pkg::fill_pattern_e pattern,
	output logic                         fill_wr,
	output logic [FILL_ADDR_BITS-1:0]    fill_addr,
	output logic [7:0]                   fill_data
);

	logic old_download;
	logic clearing;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_download <= 1'b0;
			clearing     <= 1'b0;
			fill_addr    <= '0;
		end else begin
			old_download <= cart_download;
			if (!old_download && cart_download) begin
				clearing <= 1'b1;
			end
			// Sweep ends once the last address is written
			if (&fill_addr) begin
				clearing <= 1'b0;
			end
			if (clearing) begin
				fill_addr <= fill_addr + 1'b1;
			end else begin
				fill_addr <= '0;
			end
		end
	end

	assign fill_wr = clearing;

	always_comb begin
		case (pattern)
			snes_host_pkg::FILL_9966: fill_data = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;
			snes_host_pkg::FILL_00FF: fill_data = (fill_addr[9] ^ fill_addr[0]) ? 8'hFF : 8'h00;
			snes_host_pkg::FILL_55:   fill_data = 8'h55;
			default:                  fill_data = 8'hFF;
		endcase
	end

endmodule

// File: design/backup_sector_seq.sv
// Backup-RAM sequencer moving save RAM to and from the SD image one sector at a time
`timescale 1ns/10ps

module backup_sector_seq (
	input  logic                                clk_sys,
	input  logic                                RESET,
	input  logic                                cart_download,
	input  logic                                img_mounted,
	input  logic                                img_readonly,
	input  snes_host_pkg::mask_t                ram_mask,
	input  logic                                bk_load,
	input  logic                                bk_save,
	input  logic                                sd_ack,
	output logic                                bk_enabled,
	output logic                                bk_busy,
	output logic                                bk_loading,
	output logic                                sd_rd,
	output logic                                sd_wr,
	output logic [snes_host_pkg::LBA_BITS-1:0]  sd_lba
);

	logic                               old_download;
	logic                               old_load;
	logic                               old_save;
	logic                               old_ack;
	logic                               load_edge;
	logic                               save_edge;
	logic [snes_host_pkg::LBA_BITS-1:0] last_lba;

	// Sector count follows the save-RAM size
	assign last_lba  = ram_mask[23:snes_host_pkg::SECTOR_BYTES_LOG2];
	assign load_edge = bk_load && bk_enabled && !old_load;
	assign save_edge = bk_save && bk_enabled && !old_save;

	// ==========================================================
	// Backup enable
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_download <= 1'b0;
			bk_enabled   <= 1'b0;
		end else begin
			old_download <= cart_download;
			if (!old_download && cart_download) begin
				bk_enabled <= 1'b0;
			end
			// Save image arrives while the cartridge is loading
			if (cart_download && img_mounted && !img_readonly) begin
				bk_enabled <= |ram_mask;
			end
		end
	end

	// ==========================================================
	// Sector requests
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			sd_lba     <= '0;
		end else begin
			old_load <= bk_load && bk_enabled;
			old_save <= bk_save && bk_enabled;
			old_ack  <= sd_ack;

			// Host took the request
			if (!old_ack && sd_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (!bk_busy) begin
				if (load_edge || save_edge) begin
					bk_busy    <= 1'b1;
					bk_loading <= load_edge;
					sd_lba     <= '0;
					sd_rd      <= load_edge;
					sd_wr      <= !load_edge;
				end
			end else if (old_ack && !sd_ack) begin
				if (sd_lba >= last_lba) begin
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 1'b1;
					sd_rd  <= bk_loading;
					sd_wr  <= !bk_loading;
				end
			end
		end
	end

endmodule

// File: design/audio_sat_mix.sv
// Signed audio mixer adding two samples with saturation into a registered output
`timescale 1ns/10ps

module audio_sat_mix (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  snes_host_pkg::sample_t core_sample,
	input  snes_host_pkg::sample_t ext_sample,
	output snes_host_pkg::sample_t mix_sample
);

	logic signed [16:0]     sum;
	snes_host_pkg::sample_t clamped;

	always_comb begin
		sum = {core_sample[15], core_sample} + {ext_sample[15], ext_sample};
		// Top two bits disagree on overflow and bit 16 keeps the true sign
		if (sum[16] ^ sum[15]) begin
			clamped = {sum[16], {15{sum[15]}}};
		end else begin
			clamped = sum[15:0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			mix_sample <= '0;
		end else begin
			mix_sample <= clamped;
		end
	end

endmodule

// File: design/snes_host_bridge.sv
// Cartridge-side support top level joining header detect, WRAM clear, backup and audio mix
`timescale 1ns/10ps

module snes_host_bridge #(
	parameter int FILL_ADDR_BITS = 17
) (
	input  logic                               clk_sys,
	input  logic                               RESET,
	// Download stream
	input  logic                               ioctl_download,
	input  logic [5:0]                         ioctl_index,
	input  logic                               ioctl_wr,
	input  logic [24:0]                        ioctl_addr,
	input  logic [15:0]                        ioctl_dout,
	// Menu selections
	input  snes_host_pkg::rom_header_e         header_mode,
	input  snes_host_pkg::region_e             region_mode,
	input  snes_host_pkg::fill_pattern_e       pattern,
	// SD image
	input  logic                               img_mounted,
	input  logic                               img_readonly,
	input  logic                               bk_load,
	input  logic                               bk_save,
	input  logic                               sd_ack,
	// Audio sources
	input  snes_host_pkg::sample_t             core_audio_l,
	input  snes_host_pkg::sample_t             core_audio_r,
	input  snes_host_pkg::sample_t             msu_audio_l,
	input  snes_host_pkg::sample_t             msu_audio_r,
	output logic [7:0]                         rom_type,
	output snes_host_pkg::mask_t               rom_mask,
	output snes_host_pkg::mask_t               ram_mask,
	output logic                               pal,
	output logic                               fill_wr,
	output logic [FILL_ADDR_BITS-1:0]          fill_addr,
	output logic [7:0]                         fill_data,
	output logic                               bk_enabled,
	output logic                               bk_busy,
	output logic                               bk_loading,
	output logic                               sd_rd,
	output logic                               sd_wr,
	output logic [snes_host_pkg::LBA_BITS-1:0] sd_lba,
	output snes_host_pkg::sample_t             audio_l,
	output snes_host_pkg::sample_t             audio_r
);

	logic cart_download;

	assign cart_download = ioctl_download && (ioctl_index == snes_host_pkg::CART_INDEX);

	// ==========================================================
	// Cartridge handling
	// ==========================================================
	cart_header_detect u_header (
		.clk_sys(clk_sys), .RESET(RESET), .cart_download(cart_download),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.header_mode(header_mode), .region_mode(region_mode),
		.rom_type(rom_type), .rom_mask(rom_mask), .ram_mask(ram_mask), .pal(pal)
	);

	wram_clear #(.FILL_ADDR_BITS(FILL_ADDR_BITS)) u_wram_clear (
		.clk_sys(clk_sys), .RESET(RESET), .cart_download(cart_download),
		.pattern(pattern),
		.fill_wr(fill_wr), .fill_addr(fill_addr), .fill_data(fill_data)
	);

	// Save-RAM size from the header sets the sector count
	backup_sector_seq u_backup (
		.clk_sys(clk_sys), .RESET(RESET), .cart_download(cart_download),
		.img_mounted(img_mounted), .img_readonly(img_readonly), .ram_mask(ram_mask),
		.bk_load(bk_load), .bk_save(bk_save), .sd_ack(sd_ack),
		.bk_enabled(bk_enabled), .bk_busy(bk_busy), .bk_loading(bk_loading),
		.sd_rd(sd_rd), .sd_wr(sd_wr), .sd_lba(sd_lba)
	);

	// ==========================================================
	// Audio mixing of core and MSU streams per channel
	// ==========================================================
	audio_sat_mix u_mix_l (
		.clk_sys(clk_sys), .RESET(RESET),
		.core_sample(core_audio_l), .ext_sample(msu_audio_l), .mix_sample(audio_l)
	);

	audio_sat_mix u_mix_r (
		.clk_sys(clk_sys), .RESET(RESET),
		.core_sample(core_audio_r), .ext_sample(msu_audio_r), .mix_sample(audio_r)
	);

endmodule

// File: verif/snes_host_bridge_properties.sv
// Protocol checks on the backup sector requests and the work-RAM sweep
`timescale 1ns/10ps

module snes_host_bridge_properties #(
	parameter int FILL_ADDR_BITS = 17
) (
	input logic                               clk_sys,
	input logic                               RESET,
	input logic                               sd_rd,
	input logic                               sd_wr,
	input logic [snes_host_pkg::LBA_BITS-1:0] sd_lba,
	input snes_host_pkg::mask_t               ram_mask,
	input logic                               bk_busy,
	input logic                               fill_wr,
	input logic [FILL_ADDR_BITS-1:0]          fill_addr
);

	int violations = 0;

	// One transfer direction at a time
	a_one_direction: assert property (@(posedge clk_sys) disable iff (RESET)
		!(sd_rd && sd_wr))
	else begin
		violations++;
		$error("SD read and write requested in the same cycle");
	end

	// Sector number stays inside the save RAM
	a_lba_in_range: assert property (@(posedge clk_sys) disable iff (RESET)
		bk_busy |-> (sd_lba <= ram_mask[23:snes_host_pkg::SECTOR_BYTES_LOG2]))
	else begin
		violations++;
		$error("Sector number beyond the save RAM size");
	end

	a_fill_step: assert property (@(posedge clk_sys) disable iff (RESET)
		(fill_wr && $past(fill_wr)) |-> (fill_addr == $past(fill_addr) + 1'b1))
	else begin
		violations++;
		$error("Fill address did not step by one during the clear");
	end

endmodule

bind snes_host_bridge snes_host_bridge_properties #(
	.FILL_ADDR_BITS(FILL_ADDR_BITS)
) seq_fill_checks (
	.clk_sys(clk_sys), .RESET(RESET), .sd_rd(sd_rd), .sd_wr(sd_wr), .sd_lba(sd_lba),
	.ram_mask(ram_mask), .bk_busy(bk_busy), .fill_wr(fill_wr), .fill_addr(fill_addr)
);

// File: verif/snes_host_bridge_tb.sv
// Directed testbench for the cartridge-side host bridge
`timescale 1ns/10ps

module snes_host_bridge_tb;

	localparam int FILL_BITS       = 10;
	localparam int FILL_WORDS      = 1 << FILL_BITS;
	localparam int DOWNLOAD_CYCLES = FILL_WORDS + 40;
	localparam int TRANSFER_CYCLES = 16 * 14;
	localparam int WATCHDOG_CYCLES = 20 + 5 * DOWNLOAD_CYCLES + 3 * TRANSFER_CYCLES + 300;

	logic                               clk_sys = 1'b0;
	logic                               RESET;
	logic                               ioctl_download;
	logic [5:0]                         ioctl_index;
	logic                               ioctl_wr;
	logic [24:0]                        ioctl_addr;
	logic [15:0]                        ioctl_dout;
	snes_host_pkg::rom_header_e         header_mode;
	snes_host_pkg::region_e             region_mode;
	snes_host_pkg::fill_pattern_e       pattern;
	logic                               img_mounted;
	logic                               img_readonly;
	logic                               bk_load;
	logic                               bk_save;
	logic                               sd_ack;
	snes_host_pkg::sample_t             core_audio_l;
	snes_host_pkg::sample_t             core_audio_r;
	snes_host_pkg::sample_t             msu_audio_l;
	snes_host_pkg::sample_t             msu_audio_r;
	logic [7:0]                         rom_type;
	snes_host_pkg::mask_t               rom_mask;
	snes_host_pkg::mask_t               ram_mask;
	logic                               pal;
	logic                               fill_wr;
	logic [FILL_BITS-1:0]               fill_addr;
	logic [7:0]                         fill_data;
	logic                               bk_enabled;
	logic                               bk_busy;
	logic                               bk_loading;
	logic                               sd_rd;
	logic                               sd_wr;
	logic [snes_host_pkg::LBA_BITS-1:0] sd_lba;
	snes_host_pkg::sample_t             audio_l;
	snes_host_pkg::sample_t             audio_r;

	int checks;
	int value_errors;
	int other_errors;

	snes_host_bridge #(.FILL_ADDR_BITS(FILL_BITS)) UUT (.*);

	always #50 clk_sys = ~clk_sys;

	// ==========================================================
	// Reference rules and checking
	// ==========================================================
	function automatic snes_host_pkg::mask_t mask_for_code(input int code);
		return snes_host_pkg::mask_t'((1024 << code) - 1);
	endfunction

	function automatic logic [7:0] fill_byte(input snes_host_pkg::fill_pattern_e pat,
		input logic [31:0] a);
		case (pat)
			snes_host_pkg::FILL_9966: return (a[8] != a[2]) ? 8'h66 : 8'h99;
			snes_host_pkg::FILL_00FF: return (a[9] != a[0]) ? 8'hFF : 8'h00;
			snes_host_pkg::FILL_55:   return 8'h55;
			default:                  return 8'hFF;
		endcase
	endfunction

	function automatic snes_host_pkg::sample_t clamp_sum(input int a, input int b);
		int s;
		s = a + b;
		if (s > 32767) begin
			s = 32767;
		end else if (s < -32768) begin
			s = -32768;
		end
		return snes_host_pkg::sample_t'(s);
	endfunction

	task automatic expect_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			value_errors++;
			$display("FAIL t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
		end
	endtask

	task automatic expect_true(input logic ok, input string what);
		checks++;
		assert (ok) else begin
			other_errors++;
			$display("ERROR t=%0t %s", $time, what);
		end
	endtask

	// ==========================================================
	// Bus drivers
	// ==========================================================
	task automatic begin_download(input logic mount, input logic readonly);
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		ioctl_index    <= snes_host_pkg::CART_INDEX;
		img_mounted    <= mount;
		img_readonly   <= readonly;
	endtask

	task automatic write_word(input logic [24:0] addr, input logic [15:0] data);
		@(posedge clk_sys);
		ioctl_wr   <= 1'b1;
		ioctl_addr <= addr;
		ioctl_dout <= data;
		@(posedge clk_sys);
		ioctl_wr   <= 1'b0;
	endtask

	// Ends the download and lets the WRAM sweep run out
	task automatic finish_download();
		int n;
		n = 0;
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		img_mounted    <= 1'b0;
		@(negedge clk_sys);
		while (fill_wr && n < DOWNLOAD_CYCLES) begin
			@(negedge clk_sys);
			n++;
		end
		expect_true(!fill_wr, "work-RAM clear never finished");
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic start_backup(input logic load);
		@(posedge clk_sys);
		bk_load <= load;
		bk_save <= !load;
		@(posedge clk_sys);
		bk_load <= 1'b0;
		bk_save <= 1'b0;
	endtask

	task automatic wait_request();
		int n;
		n = 0;
		@(negedge clk_sys);
		while (!(sd_rd || sd_wr) && n < 12) begin
			@(negedge clk_sys);
			n++;
		end
		expect_true(sd_rd || sd_wr, "no SD request arrived in time");
	endtask

	// Answers every sector request with an ack pulse of random length
	task automatic serve_transfer(input logic load, input int last);
		int hold;
		int n;
		for (int s = 0; s <= last; s++) begin
			wait_request();
			expect_value("sd_rd", sd_rd, load);
			expect_value("sd_wr", sd_wr, !load);
			expect_value("sd_lba", sd_lba, s);
			expect_value("bk_loading", bk_loading, load);
			hold = 1 + int'($urandom % 4);
			@(posedge clk_sys);
			sd_ack <= 1'b1;
			repeat (hold) @(posedge clk_sys);
			sd_ack <= 1'b0;
		end
		n = 0;
		@(negedge clk_sys);
		while (bk_busy && n < 8) begin
			@(negedge clk_sys);
			n++;
		end
		expect_true(!bk_busy, "backup transfer still busy after the last acknowledge");
		expect_value("sd_rd", sd_rd, 0);
		expect_value("sd_wr", sd_wr, 0);
	endtask

	// ==========================================================
	// Directed tests
	// ==========================================================
	task automatic test_reset_state();
		@(negedge clk_sys);
		expect_value("fill_wr", fill_wr, 0);
		expect_value("sd_rd", sd_rd, 0);
		expect_value("sd_wr", sd_wr, 0);
		expect_value("bk_busy", bk_busy, 0);
		expect_value("bk_loading", bk_loading, 0);
		expect_value("bk_enabled", bk_enabled, 0);
		expect_value("audio_l", audio_l, 0);
		expect_value("audio_r", audio_r, 0);
	endtask

	task automatic test_auto_header();
		@(posedge clk_sys);
		header_mode <= snes_host_pkg::HDR_AUTO;
		region_mode <= snes_host_pkg::REG_AUTO;
		begin_download(1'b0, 1'b0);
		write_word(25'd0, 16'h0A33);
		@(negedge clk_sys);
		expect_value("rom_type", rom_type, 8'h0A);
		expect_value("rom_mask", rom_mask, mask_for_code(3));
		expect_value("ram_mask", ram_mask, mask_for_code(3));
		write_word(25'd2, 16'h0100);
		finish_download();
		expect_value("pal", pal, 1);
	endtask

	task automatic test_mapped_header();
		@(posedge clk_sys);
		header_mode <= snes_host_pkg::HDR_HIROM;
		region_mode <= snes_host_pkg::REG_NTSC;
		begin_download(1'b0, 1'b0);
		write_word(25'd0, 16'h0000);
		// HiROM info word FFD6 behind the 512-byte copier header
		write_word(25'h101D6, 16'h0B00);
		write_word(25'h101D8, 16'h0002);
		@(negedge clk_sys);
		expect_value("rom_type", rom_type, 8'h01);
		expect_value("rom_mask", rom_mask, mask_for_code(11));
		expect_value("ram_mask", ram_mask, mask_for_code(2));
		finish_download();
		expect_value("pal", pal, 0);
	endtask

	task automatic test_wram_clear();
		snes_host_pkg::fill_pattern_e pat;
		pat = snes_host_pkg::fill_pattern_e'($urandom % 4);
		@(posedge clk_sys);
		pattern <= pat;
		begin_download(1'b0, 1'b0);
		@(negedge clk_sys);
		expect_value("fill_wr", fill_wr, 0);
		for (int k = 0; k < FILL_WORDS; k++) begin
			@(negedge clk_sys);
			expect_value("fill_wr", fill_wr, 1);
			expect_value("fill_addr", fill_addr, k);
			expect_value("fill_data", fill_data, fill_byte(pat, k));
		end
		@(negedge clk_sys);
		expect_value("fill_wr", fill_wr, 0);
		finish_download();
	endtask

	task automatic test_backup_load();
		@(posedge clk_sys);
		header_mode <= snes_host_pkg::HDR_AUTO;
		begin_download(1'b1, 1'b0);
		write_word(25'd0, 16'h0A33);
		finish_download();
		expect_value("bk_enabled", bk_enabled, 1);
		expect_value("ram_mask", ram_mask, 24'h001FFF);
		start_backup(1'b1);
		serve_transfer(1'b1, 15);
	endtask

	task automatic test_backup_save_gating();
		start_backup(1'b0);
		serve_transfer(1'b0, 15);
		// Readonly image keeps backup off
		begin_download(1'b1, 1'b1);
		write_word(25'd0, 16'h0A33);
		finish_download();
		expect_value("bk_enabled", bk_enabled, 0);
		start_backup(1'b0);
		start_backup(1'b1);
		repeat (20) begin
			@(negedge clk_sys);
			expect_true(!(sd_rd || sd_wr || bk_busy), "request issued with backup disabled");
		end
	endtask

	task automatic test_audio_mix();
		int a_l;
		int b_l;
		int a_r;
		int b_r;
		for (int i = 0; i < 24; i++) begin
			a_r = int'($urandom % 65536) - 32768;
			b_r = int'($urandom % 65536) - 32768;
			case (i)
				0: begin
					a_l = 32767;
					b_l = 32767;
				end
				1: begin
					a_l = -32768;
					b_l = -32768;
				end
				2: begin
					a_l = 32767;
					b_l = -32768;
				end
				3: begin
					a_l = -32768;
					b_l = -1;
				end
				default: begin
					a_l = int'($urandom % 65536) - 32768;
					b_l = int'($urandom % 65536) - 32768;
				end
			endcase
			@(posedge clk_sys);
			core_audio_l <= snes_host_pkg::sample_t'(a_l);
			msu_audio_l  <= snes_host_pkg::sample_t'(b_l);
			core_audio_r <= snes_host_pkg::sample_t'(a_r);
			msu_audio_r  <= snes_host_pkg::sample_t'(b_r);
			@(posedge clk_sys);
			@(negedge clk_sys);
			expect_value("audio_l", audio_l, clamp_sum(a_l, b_l));
			expect_value("audio_r", audio_r, clamp_sum(a_r, b_r));
		end
	endtask

	// ==========================================================
	// Watchdog and main sequence
	// ==========================================================
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("ERROR watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		void'($urandom(99));
		checks         = 0;
		value_errors   = 0;
		other_errors   = 0;
		RESET          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = 6'd0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		header_mode    = snes_host_pkg::HDR_AUTO;
		region_mode    = snes_host_pkg::REG_AUTO;
		pattern        = snes_host_pkg::FILL_9966;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		bk_load        = 1'b0;
		bk_save        = 1'b0;
		sd_ack         = 1'b0;
		core_audio_l   = '0;
		core_audio_r   = '0;
		msu_audio_l    = '0;
		msu_audio_r    = '0;
		repeat (10) @(posedge clk_sys);
		test_reset_state();
		@(posedge clk_sys);
		RESET <= 1'b0;

		test_auto_header();
		test_mapped_header();
		test_wram_clear();
		test_backup_load();
		test_backup_save_gating();
		test_audio_mix();

		$display("Summary: %0d checks, %0d value errors, %0d other errors, %0d property failures",
			checks, value_errors, other_errors, UUT.seq_fill_checks.violations);
		if (value_errors == 0 && other_errors == 0 && UUT.seq_fill_checks.violations == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: snes_host_bridge.f
design/snes_host_pkg.sv
design/cart_header_detect.sv
design/wram_clear.sv
design/backup_sector_seq.sv
design/audio_sat_mix.sv
design/snes_host_bridge.sv
verif/snes_host_bridge_properties.sv
verif/snes_host_bridge_tb.sv

// File: Makefile
# Verilator build and run for the host bridge testbench

VERILATOR ?= verilator
TOP       ?= snes_host_bridge_tb
FILELIST  ?= snes_host_bridge.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS RUN_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
